/* cmd_pkg.sv */
package cmd_pkg;

    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;

    // controller opcodes
    localparam byte_t OP_SET_LIMIT_LO = 8'h02;
    localparam byte_t OP_SET_LIMIT_HI = 8'h03;
    localparam byte_t OP_CONVERT      = 8'h04;
    localparam byte_t OP_ALARM_EN     = 8'h05;
    localparam byte_t OP_RD_LSB       = 8'h0a;
    localparam byte_t OP_RD_MSB       = 8'h0b;
    localparam byte_t OP_RD_STRING    = 8'h0d;

    // sensor bus opcodes
    localparam byte_t OP_SNS_RST      = 8'h80;
    localparam byte_t OP_SNS_WR       = 8'h81;
    localparam byte_t OP_SNS_RD_LSB   = 8'h82;
    localparam byte_t OP_SNS_RD_MSB   = 8'h83;

    // transmitter buffer depth seen by the reply path
    localparam int TX_CREDITS = 2;
    localparam int CREDIT_W   = $clog2(TX_CREDITS + 1);

endpackage

/* temp_pkg.sv */
package temp_pkg;

    localparam int RAW_W      = 11;
    localparam int SCALED_W   = 21;
    localparam int NUM_DIGITS = 7;
    localparam int BCD_W      = 4;
    localparam int WHOLE_W    = 8;
    localparam int STRING_LEN = 10;
    localparam int STR_IDX_W  = $clog2(STRING_LEN);

    // raw lsb is 1/16 degree, i.e. 625 ten-thousandths
    localparam logic [SCALED_W-1:0] TEMP_SCALE = 21'd625;
    localparam logic [SCALED_W-1:0] DEC_BASE   = 21'd10;
    localparam logic [SCALED_W-1:0] WHOLE_DIV  = 21'd10000;

    typedef logic [BCD_W-1:0]                    bcd_t;
    typedef logic [(NUM_DIGITS+1)*BCD_W-1:0]     temp_bcd_t;
    typedef logic signed [WHOLE_W-1:0]           whole_t;

    localparam bcd_t SIGN_NEG = 4'hf;

    localparam logic [7:0] ASCII_PLUS  = 8'h2b;
    localparam logic [7:0] ASCII_MINUS = 8'h2d;
    localparam logic [7:0] ASCII_DOT   = 8'h2e;
    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_LF    = 8'h0a;

endpackage

/* cmd_framer.sv */
`timescale 1ns/1ns

module cmd_framer import cmd_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t rx_byte,
    input  logic  rx_vld,
    output logic  cmd_vld,
    output byte_t cmd_op,
    output byte_t cmd_arg
);

    // low while waiting for the opcode byte
    logic  phase;
    byte_t op_hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= 1'b0;
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= rx_vld && phase;
            if (rx_vld) begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_vld && !phase) begin
            op_hold <= rx_byte;
        end
        if (rx_vld && phase) begin
            cmd_op  <= op_hold;
            cmd_arg <= rx_byte;
        end
    end

endmodule

/* sensor_port.sv */
`timescale 1ns/1ns

module sensor_port import cmd_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cmd_vld,
    input  byte_t cmd_op,
    input  byte_t cmd_arg,
    input  logic  sensor_rdy,
    input  byte_t sensor_rdata,
    input  logic  sensor_rdata_vld,
    output logic  sensor_rst,
    output logic  sensor_wr,
    output byte_t sensor_wdata,
    output logic  sensor_rd,
    output byte_t raw_lsb,
    output byte_t raw_msb
);

    typedef enum logic [1:0] {REQ_RST, REQ_WR, REQ_RD} req_e;

    logic pending;
    req_e held_kind;
    req_e new_kind;
    req_e fire_kind;
    logic held_msb;
    logic new_msb;
    logic fire_msb;
    logic is_sns_op;
    logic accept;
    logic fire;
    logic rd_busy;
    logic rd_msb;

    always_comb begin
        is_sns_op = 1'b1;
        new_kind  = REQ_RST;
        new_msb   = 1'b0;
        case (cmd_op)
            OP_SNS_RST:    new_kind = REQ_RST;
            OP_SNS_WR:     new_kind = REQ_WR;
            OP_SNS_RD_LSB: new_kind = REQ_RD;
            OP_SNS_RD_MSB: begin
                new_kind = REQ_RD;
                new_msb  = 1'b1;
            end
            default:       is_sns_op = 1'b0;
        endcase
    end

    // busy drops the command, rdy low parks it
    assign accept    = cmd_vld && is_sns_op && !pending && !rd_busy;
    assign fire      = sensor_rdy && (pending || accept);
    assign fire_kind = pending ? held_kind : new_kind;
    assign fire_msb  = pending ? held_msb : new_msb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            held_kind <= REQ_RST;
            held_msb  <= 1'b0;
        end else if (accept && !sensor_rdy) begin
            pending   <= 1'b1;
            held_kind <= new_kind;
            held_msb  <= new_msb;
        end else if (fire) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sensor_rst <= 1'b0;
            sensor_wr  <= 1'b0;
            sensor_rd  <= 1'b0;
        end else begin
            sensor_rst <= fire && (fire_kind == REQ_RST);
            sensor_wr  <= fire && (fire_kind == REQ_WR);
            sensor_rd  <= fire && (fire_kind == REQ_RD);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && new_kind == REQ_WR) begin
            sensor_wdata <= cmd_arg;
        end
    end

    // one read in flight, remember which byte it targets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            rd_msb  <= 1'b0;
            raw_lsb <= '0;
            raw_msb <= '0;
        end else if (fire && fire_kind == REQ_RD) begin
            rd_busy <= 1'b1;
            rd_msb  <= fire_msb;
        end else if (rd_busy && sensor_rdata_vld) begin
            rd_busy <= 1'b0;
            if (rd_msb) begin
                raw_msb <= sensor_rdata;
            end else begin
                raw_lsb <= sensor_rdata;
            end
        end
    end

endmodule

/* temp_converter.sv */
`timescale 1ns/1ns

module temp_converter import cmd_pkg::*, temp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_vld,
    input  byte_t     cmd_op,
    input  byte_t     raw_lsb,
    input  byte_t     raw_msb,
    output temp_bcd_t temp_bcd,
    output whole_t    temp_whole
);

    logic                  neg;
    logic [RAW_W-1:0]      raw_mag;
    logic [RAW_W-1:0]      mag;
    logic [SCALED_W-1:0]   scaled;
    logic [SCALED_W-1:0]   rem;
    logic [SCALED_W-1:0]   whole_mag;
    whole_t                whole_abs;
    bcd_t [NUM_DIGITS-1:0] digit;

    assign neg     = raw_msb[7];
    assign raw_mag = {raw_msb[2:0], raw_lsb};
    assign mag     = neg ? (~raw_mag + 1'b1) : raw_mag;
    // ten-thousandths of a degree
    assign scaled  = mag * TEMP_SCALE;

    // digit 0 is the last fraction digit
    always_comb begin
        rem = scaled;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            digit[i] = bcd_t'(rem % DEC_BASE);
            rem      = rem / DEC_BASE;
        end
    end

    assign whole_mag = scaled / WHOLE_DIV;
    assign whole_abs = whole_t'(whole_mag[WHOLE_W-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            temp_bcd   <= '0;
            temp_whole <= '0;
        end else if (cmd_vld && cmd_op == OP_CONVERT) begin
            temp_bcd   <= {(neg ? SIGN_NEG : bcd_t'(0)), digit};
            temp_whole <= neg ? -whole_abs : whole_abs;
        end
    end

endmodule

/* alarm_unit.sv */
`timescale 1ns/1ns

module alarm_unit import cmd_pkg::*, temp_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmd_vld,
    input  byte_t  cmd_op,
    input  byte_t  cmd_arg,
    input  whole_t temp_whole,
    output logic   alarm_n
);

    whole_t limit_lo;
    whole_t limit_hi;
    logic   alarm_en;
    logic   out_of_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            limit_lo <= '0;
            limit_hi <= '0;
            alarm_en <= 1'b0;
        end else if (cmd_vld) begin
            case (cmd_op)
                OP_SET_LIMIT_LO: limit_lo <= whole_t'(cmd_arg);
                OP_SET_LIMIT_HI: limit_hi <= whole_t'(cmd_arg);
                OP_ALARM_EN: begin
                    // anything but 0 or 1 leaves the enable alone
                    if (cmd_arg == byte_t'(1)) begin
                        alarm_en <= 1'b1;
                    end else if (cmd_arg == byte_t'(0)) begin
                        alarm_en <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    assign out_of_range = (temp_whole > limit_hi) || (temp_whole <= limit_lo);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alarm_n <= 1'b1;
        end else begin
            alarm_n <= !(alarm_en && out_of_range);
        end
    end

endmodule

/* reply_unit.sv */
`timescale 1ns/1ns

module reply_unit import cmd_pkg::*, temp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_vld,
    input  byte_t     cmd_op,
    input  byte_t     raw_lsb,
    input  byte_t     raw_msb,
    input  temp_bcd_t temp_bcd,
    input  logic      tx_credit,
    output byte_t     tx_byte,
    output logic      tx_vld
);

    logic [CREDIT_W-1:0]  credits;
    logic                 busy;
    logic                 mode_str;
    logic [STR_IDX_W-1:0] idx;
    temp_bcd_t            snap;
    byte_t                single;
    logic                 is_reply;
    logic                 new_str;
    byte_t                new_single;
    logic                 start;
    logic                 send;
    logic                 cur_str;
    logic [STR_IDX_W-1:0] cur_idx;
    temp_bcd_t            cur_snap;
    byte_t                cur_single;
    logic                 last;
    byte_t                str_byte;
    int                   pos;

    function automatic byte_t to_ascii(input bcd_t d);
        return byte_t'(ASCII_ZERO + {4'h0, d});
    endfunction

    always_comb begin
        is_reply   = 1'b1;
        new_str    = 1'b0;
        new_single = raw_lsb;
        case (cmd_op)
            OP_RD_LSB:    new_single = raw_lsb;
            OP_RD_MSB:    new_single = raw_msb;
            OP_RD_STRING: new_str = 1'b1;
            default:      is_reply = 1'b0;
        endcase
    end

    // a new reply may go out in the same cycle it is decoded
    assign start      = cmd_vld && is_reply && !busy;
    assign send       = (busy || start) && (credits != '0);
    assign cur_str    = busy ? mode_str : new_str;
    assign cur_idx    = busy ? idx : '0;
    assign cur_snap   = busy ? snap : temp_bcd;
    assign cur_single = busy ? single : new_single;
    assign last       = !cur_str || (cur_idx == STR_IDX_W'(STRING_LEN - 1));

    // sign, hundreds tens units, dot, four fraction digits, LF
    always_comb begin
        pos      = int'(cur_idx);
        str_byte = ASCII_LF;
        if (pos == 0) begin
            str_byte = (cur_snap[NUM_DIGITS*BCD_W +: BCD_W] == SIGN_NEG) ?
                       ASCII_MINUS : ASCII_PLUS;
        end else if (pos <= 3) begin
            str_byte = to_ascii(cur_snap[BCD_W*(7-pos) +: BCD_W]);
        end else if (pos == 4) begin
            str_byte = ASCII_DOT;
        end else if (pos <= 8) begin
            str_byte = to_ascii(cur_snap[BCD_W*(8-pos) +: BCD_W]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mode_str <= 1'b0;
            idx      <= '0;
        end else if (send) begin
            busy     <= !last;
            mode_str <= cur_str;
            idx      <= cur_idx + 1'b1;
        end else if (start) begin
            busy     <= 1'b1;
            mode_str <= new_str;
            idx      <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            snap   <= temp_bcd;
            single <= new_single;
        end
        if (send) begin
            tx_byte <= cur_str ? str_byte : cur_single;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_vld  <= 1'b0;
            credits <= CREDIT_W'(TX_CREDITS);
        end else begin
            tx_vld <= send;
            case ({send, tx_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* temp_ctrl_top.sv */
`timescale 1ns/1ns

module temp_ctrl_top import cmd_pkg::*, temp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  byte_t     rx_byte,
    input  logic      rx_vld,
    input  logic      sensor_rdy,
    input  byte_t     sensor_rdata,
    input  logic      sensor_rdata_vld,
    input  logic      tx_credit,
    output logic      sensor_rst,
    output logic      sensor_wr,
    output byte_t     sensor_wdata,
    output logic      sensor_rd,
    output byte_t     tx_byte,
    output logic      tx_vld,
    output logic      alarm_n,
    output temp_bcd_t temp_bcd
);

    // shared command bus
    logic   cmd_vld;
    byte_t  cmd_op;
    byte_t  cmd_arg;

    byte_t  raw_lsb;
    byte_t  raw_msb;
    whole_t temp_whole;

    cmd_framer u_framer (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_byte (rx_byte),
        .rx_vld  (rx_vld),
        .cmd_vld (cmd_vld),
        .cmd_op  (cmd_op),
        .cmd_arg (cmd_arg)
    );

    sensor_port u_sensor (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd_vld          (cmd_vld),
        .cmd_op           (cmd_op),
        .cmd_arg          (cmd_arg),
        .sensor_rdy       (sensor_rdy),
        .sensor_rdata     (sensor_rdata),
        .sensor_rdata_vld (sensor_rdata_vld),
        .sensor_rst       (sensor_rst),
        .sensor_wr        (sensor_wr),
        .sensor_wdata     (sensor_wdata),
        .sensor_rd        (sensor_rd),
        .raw_lsb          (raw_lsb),
        .raw_msb          (raw_msb)
    );

    temp_converter u_conv (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_vld    (cmd_vld),
        .cmd_op     (cmd_op),
        .raw_lsb    (raw_lsb),
        .raw_msb    (raw_msb),
        .temp_bcd   (temp_bcd),
        .temp_whole (temp_whole)
    );

    alarm_unit u_alarm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_vld    (cmd_vld),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg),
        .temp_whole (temp_whole),
        .alarm_n    (alarm_n)
    );

    reply_unit u_reply (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vld   (cmd_vld),
        .cmd_op    (cmd_op),
        .raw_lsb   (raw_lsb),
        .raw_msb   (raw_msb),
        .temp_bcd  (temp_bcd),
        .tx_credit (tx_credit),
        .tx_byte   (tx_byte),
        .tx_vld    (tx_vld)
    );

endmodule

/* temp_ctrl_checker.sv */
`timescale 1ns/1ns

module temp_ctrl_checker import cmd_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic tx_vld,
    input logic tx_credit,
    input logic sensor_rst,
    input logic sensor_wr,
    input logic sensor_rd
);

    // bytes sent but not yet credited back
    logic [3:0] outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + {3'b000, tx_vld} - {3'b000, tx_credit};
        end
    end

    a_credit_gate: assert property (@(posedge clk) disable iff (!rst_n)
        tx_vld |-> (outstanding < 4'(TX_CREDITS)))
        else $error("tx_vld while all credits are spent");

    a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sensor_rst, sensor_wr, sensor_rd}))
        else $error("several sensor pulses at once");

    a_rst_short: assert property (@(posedge clk) disable iff (!rst_n)
        sensor_rst |=> !sensor_rst)
        else $error("sensor_rst longer than one cycle");

    a_wr_short: assert property (@(posedge clk) disable iff (!rst_n)
        sensor_wr |=> !sensor_wr)
        else $error("sensor_wr longer than one cycle");

    a_rd_short: assert property (@(posedge clk) disable iff (!rst_n)
        sensor_rd |=> !sensor_rd)
        else $error("sensor_rd longer than one cycle");

endmodule

bind temp_ctrl_top temp_ctrl_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_vld     (tx_vld),
    .tx_credit  (tx_credit),
    .sensor_rst (sensor_rst),
    .sensor_wr  (sensor_wr),
    .sensor_rd  (sensor_rd)
);

/* tb_temp_ctrl.sv */
`timescale 1ns/1ns

module tb_temp_ctrl import cmd_pkg::*, temp_pkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam int SETTLE     = 8;
    // a string row waits up to eight cycles per byte for a credit
    localparam int ROW_CYCLES = 150;
    localparam int NUM_ROWS   = 24;
    localparam int TIMEOUT_NS = (2 + NUM_ROWS * ROW_CYCLES) * CLK_PERIOD;

    // opcode, argument, alarm_n expected once the row has settled
    // limits 20/30 then 24 against +25, limit -10 then -11 against -10
    localparam logic [16:0] CMD_TABLE [NUM_ROWS] = '{
        {OP_SNS_RST,      8'h00, 1'b1},
        {OP_SNS_WR,       8'h4e, 1'b1},
        {OP_SNS_WR,       8'h7f, 1'b1},
        {OP_SNS_RD_LSB,   8'h00, 1'b1},
        {OP_SNS_RD_MSB,   8'h00, 1'b1},
        {OP_RD_LSB,       8'h00, 1'b1},
        {OP_RD_MSB,       8'h00, 1'b1},
        {OP_CONVERT,      8'h00, 1'b1},
        {OP_RD_STRING,    8'h00, 1'b1},
        {OP_SET_LIMIT_LO, 8'h14, 1'b1},
        {OP_SET_LIMIT_HI, 8'h1e, 1'b1},
        {OP_ALARM_EN,     8'h01, 1'b1},
        {OP_SET_LIMIT_HI, 8'h18, 1'b0},
        {OP_ALARM_EN,     8'h07, 1'b0},
        {OP_ALARM_EN,     8'h00, 1'b1},
        {OP_SNS_RD_LSB,   8'h00, 1'b1},
        {OP_SNS_RD_MSB,   8'h00, 1'b1},
        {OP_CONVERT,      8'h00, 1'b1},
        {OP_RD_STRING,    8'h00, 1'b1},
        {OP_SET_LIMIT_LO, 8'hf6, 1'b1},
        {OP_ALARM_EN,     8'h01, 1'b0},
        {OP_SET_LIMIT_LO, 8'hf5, 1'b1},
        {OP_RD_LSB,       8'h00, 1'b1},
        {OP_RD_STRING,    8'h00, 1'b1}
    };

    // +25.0625 then -10.125 with lsb first
    localparam byte_t SNS_DATA [4] = '{8'h91, 8'h01, 8'h5e, 8'hff};

    logic      clk;
    logic      rst_n;
    byte_t     rx_byte;
    logic      rx_vld;
    logic      sensor_rdy;
    byte_t     sensor_rdata;
    logic      sensor_rdata_vld;
    logic      tx_credit;
    logic      sensor_rst;
    logic      sensor_wr;
    byte_t     sensor_wdata;
    logic      sensor_rd;
    byte_t     tx_byte;
    logic      tx_vld;
    logic      alarm_n;
    temp_bcd_t temp_bcd;

    // sensor model and credit sink state
    logic [31:0] rd_seed = 32'h3ea1;
    logic [31:0] cr_seed;
    int          rd_wait = 0;
    logic        rd_pend = 1'b0;
    int          sns_idx = 0;
    int          rst_cnt = 0;
    int          wr_cnt = 0;
    int          rd_cnt = 0;
    byte_t       last_wdata = 8'h00;
    int          owed = 0;
    int          cr_wait = 0;
    byte_t       rcv_q[$];

    // reference model state
    byte_t       exp_q[$];
    int          n_checked = 0;
    int          exp_rst = 0;
    int          exp_wr = 0;
    int          exp_rd = 0;
    byte_t       exp_wdata = 8'h00;
    byte_t       m_lsb = 8'h00;
    byte_t       m_msb = 8'h00;
    int          m_sidx = 0;
    logic        m_neg = 1'b0;
    int          m_ip = 0;
    int          m_fp = 0;
    temp_bcd_t   m_bcd = '0;
    int          err_count = 0;

    temp_ctrl_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_byte          (rx_byte),
        .rx_vld           (rx_vld),
        .sensor_rdy       (sensor_rdy),
        .sensor_rdata     (sensor_rdata),
        .sensor_rdata_vld (sensor_rdata_vld),
        .tx_credit        (tx_credit),
        .sensor_rst       (sensor_rst),
        .sensor_wr        (sensor_wr),
        .sensor_wdata     (sensor_wdata),
        .sensor_rd        (sensor_rd),
        .tx_byte          (tx_byte),
        .tx_vld           (tx_vld),
        .alarm_n          (alarm_n),
        .temp_bcd         (temp_bcd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic byte_t digit_char(input int d);
        return byte_t'(ASCII_ZERO + d);
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // sensor engine answers reads after a random delay
    always @(posedge clk) begin
        sensor_rdata_vld <= 1'b0;
        if (sensor_wr) begin
            wr_cnt     <= wr_cnt + 1;
            last_wdata <= sensor_wdata;
            $display("sensor write %02h at %0t ns", sensor_wdata, $time);
        end
        if (sensor_rst) begin
            rst_cnt <= rst_cnt + 1;
            $display("sensor reset at %0t ns", $time);
        end
        if (sensor_rd) begin
            rd_cnt  <= rd_cnt + 1;
            rd_pend <= 1'b1;
            rd_wait <= 1 + int'(rd_seed[17:16]);
            rd_seed <= lcg_next(rd_seed);
        end else if (rd_pend) begin
            if (rd_wait != 0) begin
                rd_wait <= rd_wait - 1;
            end else begin
                sensor_rdata     <= SNS_DATA[sns_idx % 4];
                sensor_rdata_vld <= 1'b1;
                sns_idx          <= sns_idx + 1;
                rd_pend          <= 1'b0;
            end
        end
    end

    // reply sink returns one credit per byte after a random gap
    always @(posedge clk) begin
        tx_credit <= 1'b0;
        if (tx_vld) begin
            rcv_q.push_back(tx_byte);
            owed++;
        end
        if (owed != 0 && cr_wait == 0) begin
            tx_credit <= 1'b1;
            owed--;
            cr_wait = int'(cr_seed[18:16]);
            cr_seed = lcg_next(cr_seed);
        end else if (cr_wait != 0) begin
            cr_wait--;
        end
    end

    task automatic push_string();
        exp_q.push_back(m_neg ? ASCII_MINUS : ASCII_PLUS);
        exp_q.push_back(digit_char(m_ip / 100));
        exp_q.push_back(digit_char(m_ip / 10 % 10));
        exp_q.push_back(digit_char(m_ip % 10));
        exp_q.push_back(ASCII_DOT);
        exp_q.push_back(digit_char(m_fp / 1000));
        exp_q.push_back(digit_char(m_fp / 100 % 10));
        exp_q.push_back(digit_char(m_fp / 10 % 10));
        exp_q.push_back(digit_char(m_fp % 10));
        exp_q.push_back(ASCII_LF);
    endtask

    task automatic predict_row(input byte_t op, input byte_t arg);
        int raw;
        int mag;
        int scaled;
        case (op)
            OP_SNS_RST: exp_rst++;
            OP_SNS_WR: begin
                exp_wr++;
                exp_wdata = arg;
            end
            OP_SNS_RD_LSB: begin
                exp_rd++;
                m_lsb = SNS_DATA[m_sidx];
                m_sidx++;
            end
            OP_SNS_RD_MSB: begin
                exp_rd++;
                m_msb = SNS_DATA[m_sidx];
                m_sidx++;
            end
            OP_RD_LSB: exp_q.push_back(m_lsb);
            OP_RD_MSB: exp_q.push_back(m_msb);
            OP_CONVERT: begin
                raw     = int'({m_msb[2:0], m_lsb});
                m_neg   = m_msb[7];
                mag     = m_neg ? (2048 - raw) % 2048 : raw;
                // 1/16 degree per lsb
                scaled  = mag * 625;
                m_ip    = scaled / 10000;
                m_fp    = scaled % 10000;
                m_bcd   = {(m_neg ? 4'hf : 4'h0), bcd_t'(m_ip / 100), bcd_t'(m_ip / 10 % 10),
                           bcd_t'(m_ip % 10), bcd_t'(m_fp / 1000), bcd_t'(m_fp / 100 % 10),
                           bcd_t'(m_fp / 10 % 10), bcd_t'(m_fp % 10)};
            end
            OP_RD_STRING: push_string();
            default: ;
        endcase
    endtask

    task automatic send_cmd(input byte_t op, input byte_t arg);
        @(posedge clk);
        rx_byte <= op;
        rx_vld  <= 1'b1;
        @(posedge clk);
        rx_byte <= arg;
        @(posedge clk);
        rx_vld  <= 1'b0;
    endtask

    task automatic verify_row(input logic exp_alarm);
        int i;
        compare("sensor_rst count", rst_cnt, exp_rst);
        compare("sensor_wr count", wr_cnt, exp_wr);
        compare("sensor_rd count", rd_cnt, exp_rd);
        compare("sensor_wdata", 32'(last_wdata), 32'(exp_wdata));
        compare("temp_bcd", temp_bcd, m_bcd);
        compare("alarm_n", 32'(alarm_n), 32'(exp_alarm));
        compare("reply count", rcv_q.size(), exp_q.size());
        for (i = n_checked; i < exp_q.size(); i++) begin
            compare("tx_byte", 32'(rcv_q[i]), 32'(exp_q[i]));
        end
        n_checked = exp_q.size();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the command table did not finish", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        int    row;
        byte_t op;
        byte_t arg;
        logic  exp_alarm;
        clk              = 1'b0;
        rst_n            = 1'b0;
        rx_byte          = 8'h00;
        rx_vld           = 1'b0;
        sensor_rdy       = 1'b1;
        sensor_rdata     = 8'h00;
        sensor_rdata_vld = 1'b0;
        tx_credit        = 1'b0;
        cr_seed          = lcg_next(32'h3ea1);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (row = 0; row < NUM_ROWS; row++) begin
            op        = CMD_TABLE[row][16:9];
            arg       = CMD_TABLE[row][8:1];
            exp_alarm = CMD_TABLE[row][0];
            predict_row(op, arg);
            send_cmd(op, arg);
            while (rcv_q.size() < exp_q.size()) begin
                @(negedge clk);
            end
            repeat (SETTLE) @(negedge clk);
            verify_row(exp_alarm);
        end
        if (err_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* flist.f */
cmd_pkg.sv
temp_pkg.sv
cmd_framer.sv
sensor_port.sv
temp_converter.sv
alarm_unit.sv
reply_unit.sv
temp_ctrl_top.sv
temp_ctrl_checker.sv
tb_temp_ctrl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_temp_ctrl -f flist.f -o sim_temp_ctrl

./obj_dir/sim_temp_ctrl 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation: PASS"
else
    echo "simulation: FAIL"
    exit 1
fi
